// ==== src/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

  localparam int RENAME_WIDTH = 2;   // lanes per group
  localparam int NUM_ARCH_REGS = 32;
  localparam int XZR_IDX = 31;       // zero register
  localparam int NUM_PHYS_REGS = 64;
  localparam int PHYS_W = 6;
  localparam int ARCH_W = 5;
  localparam int NZCV_RESET_PHYS = 32;
  localparam int FREE_PER_CYCLE = 3 * RENAME_WIDTH;  // dst + extra + flags per lane
  localparam int QUEUE_DEPTH = 8;
  localparam int DATA_W = 64;        // register file word

  // derived widths
  localparam int QPTR_W = $clog2(QUEUE_DEPTH);
  localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);
  localparam int ALLOC_W = $clog2(FREE_PER_CYCLE + 1);
  localparam int FREE_CNT_W = PHYS_W + 1;

  typedef enum logic [1:0] {
    UOP_ALU,
    UOP_BL,
    UOP_BCOND
  } uopcode_t;

  typedef struct packed {
    logic [31:0]       pc;
    uopcode_t          uopcode;
    logic              valb_sel;       // operand b is a register
    logic [ARCH_W-1:0] dst;
    logic [ARCH_W-1:0] src1;
    logic [ARCH_W-1:0] src2;
    logic [15:0]       imm;
    logic              set_nzcv;
    logic              predict_taken;
    logic [31:0]       branch_target;
  } uop_t;

  typedef struct packed {
    logic [31:0]       pc;
    logic [31:0]       next_pc;
    uop_t              uop;
    logic [PHYS_W-1:0] r1_phys;
    logic [PHYS_W-1:0] r2_phys;
    logic [PHYS_W-1:0] dest_phys;
    logic [PHYS_W-1:0] nzcv_phys;
  } rob_entry_t;

endpackage

`default_nettype wire

// ==== src/rename_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_fifo #(
  parameter type payload_t = logic [7:0]
) (
  input  wire logic clk,
  input  wire logic rst_N_in,
  input  wire logic push,
  input  wire payload_t [rename_pkg::RENAME_WIDTH-1:0] push_data,
  output logic full,
  output logic head_valid,
  output payload_t [rename_pkg::RENAME_WIDTH-1:0] head_data,
  input  wire logic pop
);

  payload_t mem [rename_pkg::QUEUE_DEPTH];
  logic [rename_pkg::QPTR_W-1:0] rd_ptr;
  logic [rename_pkg::QPTR_W-1:0] wr_ptr;
  logic [rename_pkg::QCNT_W-1:0] count;
  logic do_push;
  logic do_pop;

  assign head_valid = count >= rename_pkg::RENAME_WIDTH;
  assign do_pop = pop && head_valid;  // pop on empty is ignored
  // push is taken whenever a full group still fits
  assign do_push = push && (count <= rename_pkg::QUEUE_DEPTH - rename_pkg::RENAME_WIDTH);

  // one group of margin, a registered producer may still have a push in flight
  assign full = count > rename_pkg::QUEUE_DEPTH - 2 * rename_pkg::RENAME_WIDTH;

  always_comb begin
    for (int i = 0; i < rename_pkg::RENAME_WIDTH; i++) begin
      head_data[i] = mem[(rd_ptr + i) % rename_pkg::QUEUE_DEPTH];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_N_in) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + rename_pkg::QPTR_W'(rename_pkg::RENAME_WIDTH);
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + rename_pkg::QPTR_W'(rename_pkg::RENAME_WIDTH);
      end
      count <= count
             + (do_push ? rename_pkg::QCNT_W'(rename_pkg::RENAME_WIDTH) : '0)
             - (do_pop ? rename_pkg::QCNT_W'(rename_pkg::RENAME_WIDTH) : '0);
    end
  end

  // storage, no reset
  always_ff @(posedge clk) begin
    if (do_push) begin
      for (int i = 0; i < rename_pkg::RENAME_WIDTH; i++) begin
        mem[(wr_ptr + i) % rename_pkg::QUEUE_DEPTH] <= push_data[i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/free_reg_list.sv ====
`timescale 1ns/1ps
`default_nettype none

module free_reg_list (
  input  wire logic clk,
  input  wire logic rst_N_in,
  output logic [rename_pkg::FREE_PER_CYCLE-1:0][rename_pkg::PHYS_W-1:0] free_regs,
  output logic free_ok,
  input  wire logic [rename_pkg::ALLOC_W-1:0] alloc_count,
  input  wire logic ret_valid,
  input  wire logic [rename_pkg::PHYS_W-1:0] ret_phys
);

  // one slot per physical register, so the ring never overflows
  logic [rename_pkg::PHYS_W-1:0] list [rename_pkg::NUM_PHYS_REGS];
  logic [rename_pkg::PHYS_W-1:0] head;
  logic [rename_pkg::PHYS_W-1:0] tail;
  logic [rename_pkg::FREE_CNT_W-1:0] count;

  // oldest free numbers first
  always_comb begin
    for (int k = 0; k < rename_pkg::FREE_PER_CYCLE; k++) begin
      free_regs[k] = list[head + rename_pkg::PHYS_W'(k)];
    end
  end

  assign free_ok = count >= rename_pkg::FREE_CNT_W'(rename_pkg::FREE_PER_CYCLE);

  always_ff @(posedge clk) begin
    if (!rst_N_in) begin
      // everything above the initial flags register starts out free
      for (int r = 0; r < rename_pkg::NUM_PHYS_REGS - rename_pkg::NZCV_RESET_PHYS - 1; r++) begin
        list[r] <= rename_pkg::PHYS_W'(rename_pkg::NZCV_RESET_PHYS + 1 + r);
      end
      head <= '0;
      tail <= rename_pkg::PHYS_W'(rename_pkg::NUM_PHYS_REGS - rename_pkg::NZCV_RESET_PHYS - 1);
      count <= rename_pkg::FREE_CNT_W'(
                 rename_pkg::NUM_PHYS_REGS - rename_pkg::NZCV_RESET_PHYS - 1);
    end else begin
      head <= head + rename_pkg::PHYS_W'(alloc_count);  // taken from the front
      if (ret_valid) begin
        list[tail] <= ret_phys;
        tail <= tail + 1'b1;
      end
      count <= count
             - rename_pkg::FREE_CNT_W'(alloc_count)
             + rename_pkg::FREE_CNT_W'(ret_valid);
    end
  end

endmodule

`default_nettype wire

// ==== src/rat.sv ====
`timescale 1ns/1ps
`default_nettype none

module rat (
  input  wire logic clk,
  input  wire logic rst_N_in,
  input  wire logic head_valid,
  input  wire rename_pkg::uop_t [rename_pkg::RENAME_WIDTH-1:0] head_data,
  output logic pop,
  input  wire logic [rename_pkg::FREE_PER_CYCLE-1:0][rename_pkg::PHYS_W-1:0] free_regs,
  input  wire logic free_ok,
  output logic [rename_pkg::ALLOC_W-1:0] alloc_count,
  input  wire logic out_ready,
  output logic rob_valid,
  output rename_pkg::rob_entry_t [rename_pkg::RENAME_WIDTH-1:0] rob_entries,
  output logic [rename_pkg::RENAME_WIDTH-1:0] rf_we,
  output logic [rename_pkg::RENAME_WIDTH-1:0][rename_pkg::PHYS_W-1:0] rf_index,
  output logic [rename_pkg::RENAME_WIDTH-1:0][rename_pkg::DATA_W-1:0] rf_data
);

  // entry NUM_ARCH_REGS holds the flags mapping
  logic [rename_pkg::NUM_ARCH_REGS:0][rename_pkg::PHYS_W-1:0] map_q;
  logic [rename_pkg::NUM_ARCH_REGS:0][rename_pkg::PHYS_W-1:0] map_n;

  logic advance;
  logic [rename_pkg::ALLOC_W-1:0] taken;  // running allocation index
  logic [rename_pkg::RENAME_WIDTH-1:0] use_extra;
  logic [rename_pkg::RENAME_WIDTH-1:0][rename_pkg::PHYS_W-1:0] dst_p;
  logic [rename_pkg::RENAME_WIDTH-1:0][rename_pkg::PHYS_W-1:0] extra_p;
  logic [rename_pkg::RENAME_WIDTH-1:0][rename_pkg::PHYS_W-1:0] flags_p;
  logic [rename_pkg::RENAME_WIDTH-1:0][rename_pkg::DATA_W-1:0] extra_data;
  rename_pkg::rob_entry_t [rename_pkg::RENAME_WIDTH-1:0] entry_n;

  assign advance = head_valid && free_ok && out_ready;
  assign pop = advance;
  assign alloc_count = advance ? taken : '0;

  // lanes in order; map_n carries earlier lanes' writes, giving the lane 1 bypass
  always_comb begin
    map_n = map_q;
    taken = '0;
    for (int i = 0; i < rename_pkg::RENAME_WIDTH; i++) begin
      use_extra[i] = !head_data[i].valb_sel
                   || head_data[i].src1 == rename_pkg::XZR_IDX
                   || head_data[i].src2 == rename_pkg::XZR_IDX;
      // imm wins the extra register, otherwise it holds zero for xzr
      extra_data[i] = head_data[i].valb_sel ? '0 : rename_pkg::DATA_W'(head_data[i].imm);

      dst_p[i] = free_regs[taken];   // destination always takes one
      taken = taken + 1'b1;
      extra_p[i] = free_regs[taken];
      if (use_extra[i]) begin
        taken = taken + 1'b1;
      end
      flags_p[i] = free_regs[taken];
      if (head_data[i].set_nzcv) begin
        taken = taken + 1'b1;
      end

      entry_n[i].pc = head_data[i].pc;
      if ((head_data[i].uopcode == rename_pkg::UOP_BL
           || head_data[i].uopcode == rename_pkg::UOP_BCOND)
          && head_data[i].predict_taken) begin
        entry_n[i].next_pc = head_data[i].branch_target;
      end else begin
        entry_n[i].next_pc = head_data[i].pc + 32'd4;
      end
      entry_n[i].uop = head_data[i];
      entry_n[i].r1_phys = (head_data[i].src1 == rename_pkg::XZR_IDX)
                         ? extra_p[i] : map_n[head_data[i].src1];
      entry_n[i].r2_phys = (!head_data[i].valb_sel || head_data[i].src2 == rename_pkg::XZR_IDX)
                         ? extra_p[i] : map_n[head_data[i].src2];
      entry_n[i].dest_phys = dst_p[i];
      entry_n[i].nzcv_phys = head_data[i].set_nzcv
                           ? flags_p[i] : map_n[rename_pkg::NUM_ARCH_REGS];

      // xzr destination burns a register but leaves the map alone
      if (head_data[i].dst != rename_pkg::XZR_IDX) begin
        map_n[head_data[i].dst] = dst_p[i];
      end
      if (head_data[i].set_nzcv) begin
        map_n[rename_pkg::NUM_ARCH_REGS] = flags_p[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_N_in) begin
      for (int r = 0; r < rename_pkg::NUM_ARCH_REGS; r++) begin
        map_q[r] <= rename_pkg::PHYS_W'(r);  // identity
      end
      map_q[rename_pkg::NUM_ARCH_REGS] <= rename_pkg::PHYS_W'(rename_pkg::NZCV_RESET_PHYS);
      rob_valid <= 1'b0;
      rf_we <= '0;
    end else begin
      rob_valid <= advance;
      rf_we <= advance ? use_extra : '0;
      if (advance) begin
        map_q <= map_n;
      end
    end
  end

  // payload only, qualified by rob_valid and rf_we
  always_ff @(posedge clk) begin
    rob_entries <= entry_n;
    rf_index <= extra_p;
    rf_data <= extra_data;
  end

endmodule

`default_nettype wire

// ==== src/rename_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_top (
  input  wire logic clk,
  input  wire logic rst_N_in,
  input  wire logic in_valid,
  input  wire rename_pkg::uop_t [rename_pkg::RENAME_WIDTH-1:0] in_uops,
  output logic in_ready,
  output logic rob_head_valid,
  output rename_pkg::rob_entry_t [rename_pkg::RENAME_WIDTH-1:0] rob_head_data,
  input  wire logic rob_pop,
  input  wire logic ret_valid,
  input  wire logic [rename_pkg::PHYS_W-1:0] ret_phys,
  output logic [rename_pkg::RENAME_WIDTH-1:0] rf_we,
  output logic [rename_pkg::RENAME_WIDTH-1:0][rename_pkg::PHYS_W-1:0] rf_index,
  output logic [rename_pkg::RENAME_WIDTH-1:0][rename_pkg::DATA_W-1:0] rf_data
);

  logic in_full;
  logic q_head_valid;
  rename_pkg::uop_t [rename_pkg::RENAME_WIDTH-1:0] q_head_data;
  logic q_pop;
  logic [rename_pkg::FREE_PER_CYCLE-1:0][rename_pkg::PHYS_W-1:0] free_regs;
  logic free_ok;
  logic [rename_pkg::ALLOC_W-1:0] alloc_count;
  logic out_full;
  logic rob_valid;
  rename_pkg::rob_entry_t [rename_pkg::RENAME_WIDTH-1:0] rob_entries;

  assign in_ready = !in_full;

  rename_fifo #(.payload_t(rename_pkg::uop_t)) in_q_i (
    .clk(clk), .rst_N_in(rst_N_in), .push(in_valid), .push_data(in_uops), .full(in_full),
    .head_valid(q_head_valid), .head_data(q_head_data), .pop(q_pop));

  free_reg_list free_reg_list_i (
    .clk(clk), .rst_N_in(rst_N_in), .free_regs(free_regs), .free_ok(free_ok),
    .alloc_count(alloc_count), .ret_valid(ret_valid), .ret_phys(ret_phys));

  rat rat_i (
    .clk(clk), .rst_N_in(rst_N_in), .head_valid(q_head_valid), .head_data(q_head_data),
    .pop(q_pop), .free_regs(free_regs), .free_ok(free_ok), .alloc_count(alloc_count),
    .out_ready(!out_full), .rob_valid(rob_valid), .rob_entries(rob_entries),
    .rf_we(rf_we), .rf_index(rf_index), .rf_data(rf_data));

  // drained by the reorder buffer
  rename_fifo #(.payload_t(rename_pkg::rob_entry_t)) out_q_i (
    .clk(clk), .rst_N_in(rst_N_in), .push(rob_valid), .push_data(rob_entries),
    .full(out_full), .head_valid(rob_head_valid), .head_data(rob_head_data), .pop(rob_pop));

endmodule

`default_nettype wire

// ==== verification/rename_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_assertions (
  input wire logic clk,
  input wire logic rst_N_in,
  input wire logic head_valid,
  input wire logic free_ok,
  input wire logic out_ready,
  input wire logic [rename_pkg::ALLOC_W-1:0] alloc_count,
  input wire logic rob_valid
);

  int fail_count = 0;
  logic advance;

  assign advance = head_valid && free_ok && out_ready;

  // a stalled group takes nothing from the free list
  no_alloc_on_stall: assert property (@(posedge clk) disable iff (!rst_N_in)
    !advance |-> alloc_count == '0)
    else begin
      fail_count++;
      $error("alloc_count is nonzero in a cycle without an advance");
    end

  rob_valid_after_advance: assert property (@(posedge clk) disable iff (!rst_N_in)
    advance |=> rob_valid)
    else begin
      fail_count++;
      $error("rob_valid missing one cycle after an advance");
    end

  no_rob_valid_without_advance: assert property (@(posedge clk) disable iff (!rst_N_in)
    !advance |=> !rob_valid)
    else begin
      fail_count++;
      $error("rob_valid high without an advance in the cycle before");
    end

endmodule

bind rat rename_assertions rename_assertions_i (
  .clk(clk), .rst_N_in(rst_N_in), .head_valid(head_valid), .free_ok(free_ok),
  .out_ready(out_ready), .alloc_count(alloc_count), .rob_valid(rob_valid));

`default_nettype wire

// ==== verification/rename_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_tb;

  logic clk;
  logic rst_N_in;
  logic in_valid;
  rename_pkg::uop_t [rename_pkg::RENAME_WIDTH-1:0] in_uops;
  logic in_ready;
  logic rob_head_valid;
  rename_pkg::rob_entry_t [rename_pkg::RENAME_WIDTH-1:0] rob_head_data;
  logic rob_pop;
  logic ret_valid;
  logic [rename_pkg::PHYS_W-1:0] ret_phys;
  logic [rename_pkg::RENAME_WIDTH-1:0] rf_we;
  logic [rename_pkg::RENAME_WIDTH-1:0][rename_pkg::PHYS_W-1:0] rf_index;
  logic [rename_pkg::RENAME_WIDTH-1:0][rename_pkg::DATA_W-1:0] rf_data;

  logic [31:0] seed;
  logic [31:0] r;
  logic [31:0] pc;
  int errors;
  int sva_errors;
  int cycles;
  int pushed;
  int drained;
  rename_pkg::uop_t sent_q[$];  // pushed micro-ops in order
  logic [rename_pkg::PHYS_W-1:0] free_q[$];  // shadow free list
  logic [rename_pkg::PHYS_W-1:0] ret_q[$];  // dead registers waiting for return
  logic [rename_pkg::PHYS_W-1:0] map_model [rename_pkg::NUM_ARCH_REGS+1];
  logic [rename_pkg::DATA_W-1:0] rf_model [rename_pkg::NUM_PHYS_REGS];
  bit busy [rename_pkg::NUM_PHYS_REGS];

  rename_top rename_top_i (
    .clk(clk), .rst_N_in(rst_N_in), .in_valid(in_valid), .in_uops(in_uops),
    .in_ready(in_ready), .rob_head_valid(rob_head_valid), .rob_head_data(rob_head_data),
    .rob_pop(rob_pop), .ret_valid(ret_valid), .ret_phys(ret_phys), .rf_we(rf_we),
    .rf_index(rf_index), .rf_data(rf_data));

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      errors++;
      $display("Error %s: expected %0h actual %0h", name, expected, actual);
    end
  endtask

  function automatic logic [rename_pkg::PHYS_W-1:0] take_free();
    logic [rename_pkg::PHYS_W-1:0] p;
    if (free_q.size() == 0) begin
      errors++;
      $display("the shadow free list ran empty");
      return '0;
    end
    p = free_q.pop_front();
    busy[p] = 1'b1;
    return p;
  endfunction

  function automatic rename_pkg::uop_t make_uop(input logic [31:0] uop_pc);
    rename_pkg::uop_t u;
    logic [31:0] a;
    logic [31:0] b;
    a = next_rand();
    b = next_rand();
    u.pc = uop_pc;
    case (a[31:30])
      2'd1: u.uopcode = rename_pkg::UOP_BL;
      2'd2: u.uopcode = rename_pkg::UOP_BCOND;
      default: u.uopcode = rename_pkg::UOP_ALU;
    endcase
    u.valb_sel = a[29];
    u.set_nzcv = a[28];
    u.predict_taken = a[27];
    // xzr shows up about one time in eight
    u.dst = (a[26:24] == 3'd0) ? rename_pkg::ARCH_W'(rename_pkg::XZR_IDX) : a[23:19];
    u.src1 = (a[18:16] == 3'd0) ? rename_pkg::ARCH_W'(rename_pkg::XZR_IDX) : a[15:11];
    u.src2 = (b[31:29] == 3'd0) ? rename_pkg::ARCH_W'(rename_pkg::XZR_IDX) : b[28:24];
    u.imm = b[23:8];
    u.branch_target = next_rand() & 32'hffff_fffc;
    return u;
  endfunction

  // replays the renaming rules in drain order
  task automatic check_entry(input rename_pkg::rob_entry_t e);
    rename_pkg::uop_t u;
    logic [rename_pkg::PHYS_W-1:0] dp;
    logic [rename_pkg::PHYS_W-1:0] ex;
    logic [rename_pkg::PHYS_W-1:0] fl;
    logic need_extra;
    logic [31:0] exp_next;
    if (sent_q.size() == 0) begin
      errors++;
      $display("an entry was drained that was never pushed");
      return;
    end
    u = sent_q.pop_front();
    check_value("entry_pc", u.pc, e.pc);
    assert (e.uop == u) else begin
      errors++;
      $display("entry payload differs from the micro-op pushed at pc %0h", u.pc);
    end
    need_extra = !u.valb_sel || u.src1 == rename_pkg::XZR_IDX || u.src2 == rename_pkg::XZR_IDX;
    ex = '0;
    fl = '0;
    // a number still mapped or in flight must not come out again
    assert (!busy[e.dest_phys]) else begin
      errors++;
      $display("register %0d was reissued before it was returned", e.dest_phys);
    end
    dp = take_free();
    if (need_extra) begin
      ex = take_free();
    end
    if (u.set_nzcv) begin
      fl = take_free();
    end
    check_value("dest_phys", dp, e.dest_phys);
    check_value("src_map", (u.src1 == rename_pkg::XZR_IDX) ? ex : map_model[u.src1], e.r1_phys);
    check_value("src_map", (!u.valb_sel || u.src2 == rename_pkg::XZR_IDX)
                ? ex : map_model[u.src2], e.r2_phys);
    if (need_extra) begin
      check_value("extra_write", u.valb_sel ? 64'd0 : 64'(u.imm), rf_model[ex]);
    end
    check_value("nzcv_map", u.set_nzcv ? fl : map_model[rename_pkg::NUM_ARCH_REGS], e.nzcv_phys);
    exp_next = ((u.uopcode == rename_pkg::UOP_BL || u.uopcode == rename_pkg::UOP_BCOND)
                && u.predict_taken) ? u.branch_target : u.pc + 32'd4;
    check_value("next_pc", exp_next, e.next_pc);
    // whatever this entry made dead goes back, as commit would
    if (u.dst != rename_pkg::XZR_IDX) begin
      ret_q.push_back(map_model[u.dst]);
      map_model[u.dst] = dp;
    end else begin
      ret_q.push_back(dp);
    end
    if (need_extra) begin
      ret_q.push_back(ex);
    end
    if (u.set_nzcv) begin
      ret_q.push_back(map_model[rename_pkg::NUM_ARCH_REGS]);
      map_model[rename_pkg::NUM_ARCH_REGS] = fl;
    end
  endtask

  initial begin
    seed = 32'h91eec277;
    errors = 0;
    cycles = 0;
    pushed = 0;
    drained = 0;
    pc = 32'h0000_1000;
    rst_N_in = 1'b0;
    in_valid = 1'b0;
    in_uops = '0;
    rob_pop = 1'b0;
    ret_valid = 1'b0;
    ret_phys = '0;
    for (int a = 0; a < rename_pkg::NUM_PHYS_REGS; a++) begin
      rf_model[a] = {32'hbad0_cafe, 32'(a)};
      busy[a] = (a <= rename_pkg::NZCV_RESET_PHYS);  // mapped at reset
      if (a <= rename_pkg::NUM_ARCH_REGS) begin
        map_model[a] = rename_pkg::PHYS_W'(a);
      end else begin
        free_q.push_back(rename_pkg::PHYS_W'(a));
      end
    end
    repeat (5) @(negedge clk);
    check_value("reset_ctrl", '0, {rob_head_valid, rf_we, rename_top_i.rat_i.rob_valid,
                rename_top_i.rat_i.pop, rename_top_i.rat_i.alloc_count,
                rename_top_i.q_head_valid});
    rst_N_in = 1'b1;

    while (drained < 300 && cycles < 20000) begin
      @(negedge clk);
      cycles++;
      for (int i = 0; i < rename_pkg::RENAME_WIDTH; i++) begin
        if (rf_we[i]) begin
          rf_model[rf_index[i]] = rf_data[i];
        end
      end
      r = next_rand();
      if (ret_q.size() > 0 && r[31:30] != 2'd0) begin
        ret_valid = 1'b1;
        ret_phys = ret_q.pop_front();
        busy[ret_phys] = 1'b0;
        free_q.push_back(ret_phys);
      end else begin
        ret_valid = 1'b0;
      end
      rob_pop = (cycles % 200 >= 80) && r[29];  // long stall every 200 cycles
      if (rob_pop && rob_head_valid) begin
        check_entry(rob_head_data[0]);
        check_entry(rob_head_data[1]);
        drained++;
      end
      if (pushed < 300 && in_ready && r[28]) begin
        in_uops[0] = make_uop(pc);
        in_uops[1] = make_uop(pc + 32'd4);
        sent_q.push_back(in_uops[0]);
        sent_q.push_back(in_uops[1]);
        pc = pc + 32'd8;
        in_valid = 1'b1;
        pushed++;
      end else begin
        in_valid = 1'b0;
      end
    end

    if (drained < 300) begin
      errors++;
      $display("timed out with %0d of 300 groups drained", drained);
    end
    sva_errors = rename_top_i.rat_i.rename_assertions_i.fail_count;
    $display("errors: %0d checks, %0d bound assertions", errors, sva_errors);
    if (errors == 0 && sva_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
src/rename_pkg.sv
src/rename_fifo.sv
src/free_reg_list.sv
src/rat.sv
src/rename_top.sv
verification/rename_assertions.sv
verification/rename_tb.sv

// ==== Bender.yml ====
package:
  name: rename_stage

sources:
  - src/rename_pkg.sv
  - src/rename_fifo.sv
  - src/free_reg_list.sv
  - src/rat.sv
  - src/rename_top.sv
  - target: simulation
    files:
      - verification/rename_assertions.sv
      - verification/rename_tb.sv
